/* common/coh_noc_pkg.sv */
/*
  Shared types, field widths and helper functions for the LCE response NoC path.
  Data is limited to 16 bytes. Packet bits are laid out from the LSB as
  cord, cid, len, then the response (header first, then data).
*/
`default_nettype none

package coh_noc_pkg;

  typedef enum logic [2:0] {
    e_sync_ack = 3'd0,
    e_inv_ack  = 3'd1,
    e_coh_ack  = 3'd2,
    e_null_wb  = 3'd3,
    e_wb       = 3'd4
  } lce_resp_msg_e;

  typedef enum logic [2:0] {
    e_size_1  = 3'd0,
    e_size_2  = 3'd1,
    e_size_4  = 3'd2,
    e_size_8  = 3'd3,
    e_size_16 = 3'd4
  } msg_size_e;

  localparam int lce_id_width_c = 2;
  localparam int cce_id_width_c = 2;
  localparam int addr_width_c   = 16;
  localparam int data_width_c   = 128;

  // response header fields, LSB first
  localparam int msg_type_lsb_c   = 0;
  localparam int size_lsb_c       = 3;
  localparam int src_id_lsb_c     = 6;
  localparam int dst_id_lsb_c     = 8;
  localparam int addr_lsb_c       = 10;
  localparam int resp_hdr_width_c = 26;
  localparam int resp_width_c     = resp_hdr_width_c + data_width_c;

  localparam int cord_width_c = 4;
  localparam int cid_width_c  = 2;
  localparam int len_width_c  = 4;
  localparam int flit_width_c = 32;

  // packet fields
  localparam int cord_lsb_c    = 0;
  localparam int cid_lsb_c     = cord_lsb_c + cord_width_c;
  localparam int len_lsb_c     = cid_lsb_c + cid_width_c;
  localparam int payload_lsb_c = len_lsb_c + len_width_c;

  localparam int packet_hdr_width_c = payload_lsb_c + resp_hdr_width_c;  // 36
  localparam int packet_flits_c =
    (packet_hdr_width_c + data_width_c + flit_width_c - 1) / flit_width_c;
  localparam int packet_width_c = packet_flits_c * flit_width_c;

  // flits needed for header plus data, minus one
  function automatic logic [len_width_c-1:0] packet_len_f(input int unsigned data_bytes);
    int unsigned bits;
    bits = packet_hdr_width_c + 8 * data_bytes;
    return len_width_c'((bits + flit_width_c - 1) / flit_width_c - 1);
  endfunction

  function automatic logic [cord_width_c-1:0] cce_cord_f(input logic [cce_id_width_c-1:0] id);
    return cord_width_c'(id >> 1) + cord_width_c'(1);
  endfunction

  function automatic logic [cid_width_c-1:0] cce_cid_f(input logic [cce_id_width_c-1:0] id);
    return cid_width_c'(id[0]);
  endfunction

endpackage

`default_nettype wire

/* lane/lce_resp_packet_encode.sv */
/*
  Pure combinational response to packet encoder.
  Data bytes beyond the message size are cleared so padding flits stay zero.
  Invalid msg_type yields an all-zero packet (len 0, one flit).
*/
`timescale 1ns/1ps
`default_nettype none

module lce_resp_packet_encode (
  input  wire logic [coh_noc_pkg::resp_width_c-1:0] resp_i,
  output logic [coh_noc_pkg::packet_width_c-1:0]    packet_o
);
  import coh_noc_pkg::*;

  lce_resp_msg_e msg_type;
  msg_size_e     size;
  logic [cce_id_width_c-1:0] dst_id;
  logic [4:0]                data_bytes;
  logic                      known;
  logic [data_width_c-1:0]   data_keep;

  always_comb begin
    msg_type   = lce_resp_msg_e'(resp_i[msg_type_lsb_c +: 3]);
    size       = msg_size_e'(resp_i[size_lsb_c +: 3]);
    dst_id     = resp_i[dst_id_lsb_c +: cce_id_width_c];
    data_bytes = 5'd0;
    known      = 1'b1;

    case (msg_type)
      e_sync_ack, e_inv_ack, e_coh_ack, e_null_wb: data_bytes = 5'd0;  // no data
      e_wb: begin
        case (size)
          e_size_1:  data_bytes = 5'd1;
          e_size_2:  data_bytes = 5'd2;
          e_size_4:  data_bytes = 5'd4;
          e_size_8:  data_bytes = 5'd8;
          e_size_16: data_bytes = 5'd16;
          default:   data_bytes = 5'd0;  // unknown size, sent like an ack
        endcase
      end
      default: known = 1'b0;
    endcase

    data_keep = ~({data_width_c{1'b1}} << (8 * data_bytes));

    packet_o = '0;
    if (known) begin
      packet_o[cord_lsb_c +: cord_width_c] = cce_cord_f(dst_id);
      packet_o[cid_lsb_c +: cid_width_c]   = cce_cid_f(dst_id);
      packet_o[len_lsb_c +: len_width_c]   = packet_len_f(int'(data_bytes));
      packet_o[payload_lsb_c +: resp_hdr_width_c] = resp_i[resp_hdr_width_c-1:0];
      packet_o[packet_hdr_width_c +: data_width_c] =
        resp_i[resp_hdr_width_c +: data_width_c] & data_keep;
    end
  end

endmodule

`default_nettype wire

/* lane/lce_resp_lane.sv */
/*
  One packet in flight per lane. The response is taken on the yumi edge and
  its flits leave from the next cycle, one per cycle while flit credits last.
  Credit count starts at lane_buf_depth_p and must match the downstream buffer.
*/
`timescale 1ns/1ps
`default_nettype none

module lce_resp_lane #(
  parameter int lane_buf_depth_p = 2
) (
  input  wire logic                                 clk_i,
  input  wire logic                                 rst_n_i,
  input  wire logic                                 resp_v_i,
  input  wire logic [coh_noc_pkg::resp_width_c-1:0] resp_i,
  output logic                                      resp_yumi_o,
  output logic                                      flit_v_o,
  output logic [coh_noc_pkg::flit_width_c-1:0]      flit_o,
  input  wire logic                                 flit_credit_i
);
  import coh_noc_pkg::*;

  localparam int credit_width_lp = $clog2(lane_buf_depth_p + 1);

  logic [packet_width_c-1:0]  packet_li;
  logic [packet_width_c-1:0]  packet_r;
  logic                       busy_r;
  logic [len_width_c-1:0]     idx_r;
  logic [len_width_c-1:0]     last_r;
  logic [credit_width_lp-1:0] credit_r;
  logic                       send;

  lce_resp_packet_encode encode_i (
    .resp_i  (resp_i),
    .packet_o(packet_li)
  );

  assign resp_yumi_o = resp_v_i & ~busy_r;
  assign send        = busy_r & (credit_r != '0);
  assign flit_v_o    = send;
  assign flit_o      = packet_r[flit_width_c-1:0];  // low flit is always next

  // control
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      busy_r <= 1'b0;
      idx_r  <= '0;
      last_r <= '0;
    end else if (resp_yumi_o) begin
      busy_r <= 1'b1;
      idx_r  <= '0;
      last_r <= packet_li[len_lsb_c +: len_width_c];
    end else if (send) begin
      if (idx_r == last_r) begin
        busy_r <= 1'b0;  // last flit gone
      end
      idx_r <= idx_r + 1'b1;
    end
  end

  // packet shift register
  always_ff @(posedge clk_i) begin
    if (resp_yumi_o) begin
      packet_r <= packet_li;
    end else if (send) begin
      packet_r <= packet_r >> flit_width_c;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      credit_r <= credit_width_lp'(lane_buf_depth_p);
    end else begin
      credit_r <= credit_r - credit_width_lp'(send) + credit_width_lp'(flit_credit_i);
    end
  end

endmodule

`default_nettype wire

/* src/resp_ingress_fifo.sv */
/*
  Credit-managed input buffer shared by all LCEs, strict FIFO order.
  Upstream must hold ingress_depth_p credits and never push without one.
  A blocked head entry stalls every source behind it.
*/
`timescale 1ns/1ps
`default_nettype none

module resp_ingress_fifo #(
  parameter int num_lce_p       = 4,
  parameter int ingress_depth_p = 4
) (
  input  wire logic                                 clk_i,
  input  wire logic                                 rst_n_i,
  input  wire logic                                 resp_v_i,
  input  wire logic [coh_noc_pkg::resp_width_c-1:0] resp_i,
  output logic                                      resp_credit_o,
  output logic [num_lce_p-1:0]                      lane_v_o,
  output logic [coh_noc_pkg::resp_width_c-1:0]      lane_resp_o,
  input  wire logic [num_lce_p-1:0]                 lane_yumi_i
);
  import coh_noc_pkg::*;

  localparam int ptr_width_lp = (ingress_depth_p > 1) ? $clog2(ingress_depth_p) : 1;
  localparam int cnt_width_lp = $clog2(ingress_depth_p + 1);

  logic [resp_width_c-1:0] mem_r [ingress_depth_p];
  logic [ptr_width_lp-1:0] rd_ptr_r;
  logic [ptr_width_lp-1:0] wr_ptr_r;
  logic [cnt_width_lp-1:0] cnt_r;
  logic [lce_id_width_c-1:0] head_src;
  logic pop;

  assign lane_resp_o = mem_r[rd_ptr_r];
  assign head_src    = lane_resp_o[src_id_lsb_c +: lce_id_width_c];

  // one-hot steer by src_id
  always_comb begin
    for (int i = 0; i < num_lce_p; i++) begin
      lane_v_o[i] = (cnt_r != '0) && (head_src == lce_id_width_c'(i));
    end
  end

  assign pop = |(lane_v_o & lane_yumi_i);

  always_ff @(posedge clk_i) begin
    if (resp_v_i) begin
      mem_r[wr_ptr_r] <= resp_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      rd_ptr_r      <= '0;
      wr_ptr_r      <= '0;
      cnt_r         <= '0;
      resp_credit_o <= 1'b0;
    end else begin
      if (resp_v_i) begin
        wr_ptr_r <= (wr_ptr_r == ptr_width_lp'(ingress_depth_p - 1)) ? '0 : wr_ptr_r + 1'b1;
      end
      if (pop) begin
        rd_ptr_r <= (rd_ptr_r == ptr_width_lp'(ingress_depth_p - 1)) ? '0 : rd_ptr_r + 1'b1;
      end
      cnt_r         <= cnt_r + cnt_width_lp'(resp_v_i) - cnt_width_lp'(pop);
      resp_credit_o <= pop;  // credit one cycle after the pop
    end
  end

endmodule

`default_nettype wire

/* src/flit_concentrator.sv */
/*
  Merges lane flit streams onto one link with wormhole round-robin arbitration.
  A lane is held from its header flit until len+1 flits have left.
  Lanes must not push more flits than lane_buf_depth_p credits allow.
*/
`timescale 1ns/1ps
`default_nettype none

module flit_concentrator #(
  parameter int num_lce_p        = 4,
  parameter int lane_buf_depth_p = 2,
  parameter int link_credits_p   = 4
) (
  input  wire logic                                             clk_i,
  input  wire logic                                             rst_n_i,
  input  wire logic [num_lce_p-1:0]                             flit_v_i,
  input  wire logic [num_lce_p-1:0][coh_noc_pkg::flit_width_c-1:0] flit_i,
  output logic [num_lce_p-1:0]                                  flit_credit_o,
  output logic                                                  link_v_o,
  output logic [coh_noc_pkg::flit_width_c-1:0]                  link_flit_o,
  input  wire logic                                             link_credit_i
);
  import coh_noc_pkg::*;

  localparam int lane_id_width_lp = (num_lce_p > 1) ? $clog2(num_lce_p) : 1;
  localparam int buf_ptr_width_lp = (lane_buf_depth_p > 1) ? $clog2(lane_buf_depth_p) : 1;
  localparam int buf_cnt_width_lp = $clog2(lane_buf_depth_p + 1);
  localparam int credit_width_lp  = $clog2(link_credits_p + 1);

  logic [num_lce_p-1:0][flit_width_c-1:0] head_flit;
  logic [num_lce_p-1:0]                   lane_ne;
  logic [lane_id_width_lp-1:0]            cur_r;  // locked lane, also rr origin
  logic [len_width_c-1:0]                 rem_r;  // body flits still to pass
  logic [lane_id_width_lp-1:0]            rr_sel;
  logic                                   rr_found;
  logic [lane_id_width_lp-1:0]            sel;
  logic                                   locked;
  logic [credit_width_lp-1:0]             credit_r;

  for (genvar i = 0; i < num_lce_p; i++) begin : g_lane_buf
    logic [flit_width_c-1:0]     mem_r [lane_buf_depth_p];
    logic [buf_ptr_width_lp-1:0] rd_r;
    logic [buf_ptr_width_lp-1:0] wr_r;
    logic [buf_cnt_width_lp-1:0] cnt_r;

    assign head_flit[i] = mem_r[rd_r];
    assign lane_ne[i]   = (cnt_r != '0);

    always_ff @(posedge clk_i) begin
      if (flit_v_i[i]) begin
        mem_r[wr_r] <= flit_i[i];
      end
    end

    always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
        rd_r  <= '0;
        wr_r  <= '0;
        cnt_r <= '0;
      end else begin
        if (flit_v_i[i]) begin
          wr_r <= (wr_r == buf_ptr_width_lp'(lane_buf_depth_p - 1)) ? '0 : wr_r + 1'b1;
        end
        if (flit_credit_o[i]) begin
          rd_r <= (rd_r == buf_ptr_width_lp'(lane_buf_depth_p - 1)) ? '0 : rd_r + 1'b1;
        end
        cnt_r <= cnt_r + buf_cnt_width_lp'(flit_v_i[i]) - buf_cnt_width_lp'(flit_credit_o[i]);
      end
    end
  end

  // next non-empty lane after the last winner
  always_comb begin
    rr_sel   = cur_r;
    rr_found = 1'b0;
    for (int k = 1; k <= num_lce_p; k++) begin
      if (!rr_found && lane_ne[(int'(cur_r) + k) % num_lce_p]) begin
        rr_sel   = lane_id_width_lp'((int'(cur_r) + k) % num_lce_p);
        rr_found = 1'b1;
      end
    end
  end

  assign locked      = (rem_r != '0);
  assign sel         = locked ? cur_r : rr_sel;
  assign link_v_o    = lane_ne[sel] && (credit_r != '0);
  assign link_flit_o = head_flit[sel];

  always_comb begin
    for (int i = 0; i < num_lce_p; i++) begin
      flit_credit_o[i] = link_v_o && (sel == lane_id_width_lp'(i));  // pop returns credit
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      cur_r <= lane_id_width_lp'(num_lce_p - 1);  // lane 0 wins first
      rem_r <= '0;
    end else if (link_v_o) begin
      if (locked) begin
        rem_r <= rem_r - 1'b1;
      end else begin
        cur_r <= rr_sel;
        rem_r <= link_flit_o[len_lsb_c +: len_width_c];  // header flit
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      credit_r <= credit_width_lp'(link_credits_p);
    end else begin
      credit_r <= credit_r - credit_width_lp'(link_v_o) + credit_width_lp'(link_credit_i);
    end
  end

endmodule

`default_nettype wire

/* src/lce_resp_noc_top.sv */
/*
  LCE response path from input credits to a single credited link.
  Latency varies with arbitration and credit stalls.
  The last flit of a packet on the link marks the packet end.
*/
`timescale 1ns/1ps
`default_nettype none

module lce_resp_noc_top #(
  parameter int num_lce_p        = 4,
  parameter int ingress_depth_p  = 4,
  parameter int lane_buf_depth_p = 2,
  parameter int link_credits_p   = 4
) (
  input  wire logic                                 clk_i,
  input  wire logic                                 rst_n_i,
  input  wire logic                                 resp_v_i,
  input  wire logic [coh_noc_pkg::resp_width_c-1:0] resp_i,
  output logic                                      resp_credit_o,
  output logic                                      link_v_o,
  output logic [coh_noc_pkg::flit_width_c-1:0]      link_flit_o,
  input  wire logic                                 link_credit_i
);
  import coh_noc_pkg::*;

  logic [num_lce_p-1:0]                   lane_v;
  logic [resp_width_c-1:0]                lane_resp;
  logic [num_lce_p-1:0]                   lane_yumi;
  logic [num_lce_p-1:0]                   flit_v;
  logic [num_lce_p-1:0][flit_width_c-1:0] flit;
  logic [num_lce_p-1:0]                   flit_credit;

  resp_ingress_fifo #(
    .num_lce_p      (num_lce_p),
    .ingress_depth_p(ingress_depth_p)
  ) resp_ingress_fifo_i (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .resp_v_i     (resp_v_i),
    .resp_i       (resp_i),
    .resp_credit_o(resp_credit_o),
    .lane_v_o     (lane_v),
    .lane_resp_o  (lane_resp),
    .lane_yumi_i  (lane_yumi)
  );

  for (genvar i = 0; i < num_lce_p; i++) begin : g_lane
    lce_resp_lane #(
      .lane_buf_depth_p(lane_buf_depth_p)
    ) lce_resp_lane_i (
      .clk_i        (clk_i),
      .rst_n_i      (rst_n_i),
      .resp_v_i     (lane_v[i]),
      .resp_i       (lane_resp),  // shared head entry
      .resp_yumi_o  (lane_yumi[i]),
      .flit_v_o     (flit_v[i]),
      .flit_o       (flit[i]),
      .flit_credit_i(flit_credit[i])
    );
  end

  flit_concentrator #(
    .num_lce_p       (num_lce_p),
    .lane_buf_depth_p(lane_buf_depth_p),
    .link_credits_p  (link_credits_p)
  ) flit_concentrator_i (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .flit_v_i     (flit_v),
    .flit_i       (flit),
    .flit_credit_o(flit_credit),
    .link_v_o     (link_v_o),
    .link_flit_o  (link_flit_o),
    .link_credit_i(link_credit_i)
  );

endmodule

`default_nettype wire

/* test/tb_lce_resp_noc.sv */
/*
  Random-stimulus testbench for the LCE response NoC path.
  Expected packets come from a model of the encoding rules, queued per src_id.
  Invalid-type packets are all zero and carry no src_id, so each one is
  settled only when a later packet of its own source leaves the link.
*/
`timescale 1ns/1ps
`default_nettype none

module tb_lce_resp_noc;
  import coh_noc_pkg::*;

  localparam int num_lce_c        = 4;
  localparam int ingress_depth_c  = 4;
  localparam int lane_buf_depth_c = 2;
  localparam int link_credits_c   = 4;
  localparam int num_resp_c       = 300;
  localparam int max_cycles_c     = num_resp_c * packet_flits_c * 8;

  logic                    clk_i;
  logic                    rst_n_i;
  logic                    resp_v_i;
  logic [resp_width_c-1:0] resp_i;
  logic                    resp_credit_o;
  logic                    link_v_o;
  logic [flit_width_c-1:0] link_flit_o;
  logic                    link_credit_i;

  logic [31:0]               lfsr_state;
  logic [packet_width_c-1:0] exp_q [num_lce_c][$];  // expected packets per src_id
  logic [packet_width_c-1:0] mon_pkt;
  int mon_idx;
  int mon_last;
  int err_value;
  int err_proto;
  int pkts;
  int zero_seen;  // zero packets out of the link, source not settled yet

  lce_resp_noc_top #(
    .num_lce_p       (num_lce_c),
    .ingress_depth_p (ingress_depth_c),
    .lane_buf_depth_p(lane_buf_depth_c),
    .link_credits_p  (link_credits_c)
  ) lce_resp_noc_top_i (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .resp_v_i     (resp_v_i),
    .resp_i       (resp_i),
    .resp_credit_o(resp_credit_o),
    .link_v_o     (link_v_o),
    .link_flit_o  (link_flit_o),
    .link_credit_i(link_credit_i)
  );

  initial begin
    clk_i = 1'b0;
    forever #20 clk_i = ~clk_i;
  end

  // galois form, x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return (s >> 1) ^ (s[0] ? 32'h8020_0003 : 32'h0);
  endfunction

  function automatic logic [127:0] rand_bits(input int n);
    logic [127:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      v[i] = lfsr_state[0];
    end
    return v;
  endfunction

  function automatic logic [resp_width_c-1:0] make_resp();
    logic [resp_width_c-1:0] r;
    r = '0;
    if (rand_bits(5) == 0) begin
      r[2:0] = 3'(5 + rand_bits(2) % 3);  // rare invalid type
    end else if (rand_bits(1) != 0) begin
      r[2:0] = 3'd4;
    end else begin
      r[2:0] = 3'(rand_bits(2));
    end
    r[5:3]   = 3'(rand_bits(3));  // codes 5..7 are unknown sizes
    r[7:6]   = 2'(rand_bits(2));
    r[9:8]   = 2'(rand_bits(2));
    r[25:10] = 16'(rand_bits(16));
    r[153:26] = rand_bits(128);
    return r;
  endfunction

  // reference encoding from the packet rules
  function automatic logic [packet_width_c-1:0] expected_packet(input logic [resp_width_c-1:0] r);
    logic [packet_width_c-1:0] p;
    int nbytes;
    logic [3:0] len;
    p = '0;
    if (r[2:0] > 3'd4) return p;
    nbytes = 0;
    if (r[2:0] == 3'd4) begin
      case (r[5:3])
        3'd0: nbytes = 1;
        3'd1: nbytes = 2;
        3'd2: nbytes = 4;
        3'd3: nbytes = 8;
        3'd4: nbytes = 16;
        default: nbytes = 0;
      endcase
    end
    case (nbytes)
      4:  len = 4'd2;
      8:  len = 4'd3;
      16: len = 4'd5;
      default: len = 4'd1;  // acks, null_wb, 1 and 2 bytes
    endcase
    p[3:0]   = 4'(r[9]) + 4'd1;
    p[5:4]   = {1'b0, r[8]};
    p[9:6]   = len;
    p[35:10] = r[25:0];
    for (int i = 0; i < nbytes; i++) begin
      p[36 + 8*i +: 8] = r[26 + 8*i +: 8];
    end
    return p;
  endfunction

  task automatic check_packet(input logic [packet_width_c-1:0] p);
    int src;
    pkts++;
    if (p == '0) begin
      zero_seen++;
    end else begin
      src = int'(p[17:16]);
      // zero packets sent earlier by this source must be out already
      while (exp_q[src].size() > 0 && exp_q[src][0] == '0) begin
        assert (zero_seen > 0) else begin
          $display("%0t: packet from src %0d overtook an invalid-type packet of its own",
                   $time, src);
          err_proto++;
        end
        if (zero_seen > 0) zero_seen--;
        void'(exp_q[src].pop_front());
      end
      assert (exp_q[src].size() > 0) else begin
        $display("%0t: packet %h came out of the link with no matching packet sent", $time, p);
        err_proto++;
      end
      if (exp_q[src].size() > 0) begin
        assert (p == exp_q[src][0]) else begin
          $display("FAILED %0t link_flit_o packet (src %0d): expected %h, got %h",
                   $time, src, exp_q[src][0], p);
          err_value++;
        end
        void'(exp_q[src].pop_front());
      end
    end
  endtask

  // gathers len+1 flits into one packet
  task automatic collect_flit(input logic [flit_width_c-1:0] f);
    if (mon_idx == 0) begin
      mon_pkt  = '0;
      mon_last = int'(f[9:6]);
      assert (mon_last < packet_flits_c) else begin
        $display("%0t: header flit %h has a length beyond the largest packet", $time, f);
        err_proto++;
        mon_last = packet_flits_c - 1;
      end
    end
    mon_pkt[mon_idx*flit_width_c +: flit_width_c] = f;
    if (mon_idx == mon_last) begin
      check_packet(mon_pkt);
      mon_idx = 0;
    end else begin
      mon_idx++;
    end
  endtask

  initial begin
    int cycles;
    int sent;
    int in_credits;
    int link_credits;  // dut's link credit count as seen from here
    int pending;       // flits taken whose credit is not back yet
    int stall_left;
    int drain;
    int queued;
    logic finished;
    logic [resp_width_c-1:0] r;
    rst_n_i = 1'b0;
    resp_v_i = 1'b0;
    resp_i = '0;
    link_credit_i = 1'b0;
    lfsr_state = 32'h40ba_8d87;
    {cycles, sent, pending, stall_left, drain, mon_idx, mon_last} = '0;
    {err_value, err_proto, pkts} = '0;
    zero_seen = 0;
    queued = 0;
    in_credits = ingress_depth_c;
    link_credits = link_credits_c;
    finished = 1'b0;
    repeat (5) @(negedge clk_i);
    assert (!link_v_o && !resp_credit_o) else begin
      $display("FAILED %0t link_v_o/resp_credit_o after reset: expected 0/0, got %0b/%0b",
               $time, link_v_o, resp_credit_o);
      err_value++;
    end
    rst_n_i = 1'b1;
    while (!finished && cycles < max_cycles_c) begin
      @(negedge clk_i);
      cycles++;
      if (resp_credit_o) begin
        in_credits++;
        assert (in_credits <= ingress_depth_c) else begin
          $display("%0t: input buffer returned more credits than were used", $time);
          err_proto++;
        end
      end
      if (link_v_o) begin
        assert (link_credits > 0) else begin
          $display("%0t: link_v_o fired with no link credit left", $time);
          err_proto++;
        end
        link_credits--;
        collect_flit(link_flit_o);
      end
      // receiver side credit return, with long stalls now and then
      link_credit_i = 1'b0;
      if (stall_left > 0) begin
        stall_left--;
      end else if (rand_bits(6) == 0) begin
        stall_left = 20 + int'(rand_bits(5));
      end else if (pending > 0 && rand_bits(2) != 0) begin
        link_credit_i = 1'b1;
        pending--;
        link_credits++;
      end
      if (link_v_o) pending++;
      resp_v_i = 1'b0;
      if (sent < num_resp_c && in_credits > 0 && rand_bits(1) != 0) begin
        r = make_resp();
        resp_i = r;
        resp_v_i = 1'b1;
        in_credits--;
        exp_q[r[7:6]].push_back(expected_packet(r));
        sent++;
      end
      queued = 0;
      for (int s = 0; s < num_lce_c; s++) begin
        queued += exp_q[s].size();
      end
      if (sent == num_resp_c && queued <= zero_seen && mon_idx == 0 && pending == 0) begin
        drain++;  // idle a while so stray flits show up
      end
      finished = (drain >= 20);
    end
    if (!finished) begin
      $display("timeout: run stopped after %0d cycles with %0d of %0d responses sent",
               cycles, sent, num_resp_c);
      err_proto++;
    end else begin
      assert (in_credits == ingress_depth_c) else begin
        $display("input credits missing at the end, %0d of %0d back", in_credits,
                 ingress_depth_c);
        err_proto++;
      end
      for (int s = 0; s < num_lce_c; s++) begin
        for (int j = 0; j < exp_q[s].size(); j++) begin
          assert (exp_q[s][j] == '0) else begin
            $display("packet %h of src %0d never came out of the link", exp_q[s][j], s);
            err_proto++;
          end
        end
      end
      assert (queued == zero_seen) else begin
        $display("invalid-type packets do not add up, %0d still expected, %0d came out",
                 queued, zero_seen);
        err_proto++;
      end
    end
    $display("summary: %0d packets checked, %0d value errors, %0d protocol errors",
             pkts, err_value, err_proto);
    if (err_value + err_proto == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* compile.f */
common/coh_noc_pkg.sv
lane/lce_resp_packet_encode.sv
lane/lce_resp_lane.sv
src/resp_ingress_fifo.sv
src/flit_concentrator.sv
src/lce_resp_noc_top.sv
test/tb_lce_resp_noc.sv

/* Makefile */
# Verilator build for the LCE response NoC testbench

VERILATOR ?= verilator
FILELIST  ?= compile.f
TOP       ?= tb_lce_resp_noc
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary -Wno-fatal

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

run: compile
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	@if grep -q "TB FAILED" $(LOG); then echo "simulation reported failure"; exit 1; fi
	@grep -q "TB PASSED" $(LOG) || (echo "simulation ended without a result"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
